/* logic/fpm_settings.svh */
// floating-point microoperation unit constants
// widths, alignment limit, fixed iteration counts, opcode positions

`ifndef FPM_SETTINGS_SVH
`define FPM_SETTINGS_SVH

`define FPM_EXP_W        8
`define FPM_GUARD_W      2
`define FPM_XEXP_W       (`FPM_EXP_W + `FPM_GUARD_W)
`define FPM_FIC_W        6
`define FPM_OP_W         3
`define FPM_OPS_W        8

// difference at which the mantissa is shifted out entirely
`define FPM_ALIGN_LIMIT  40

// counter preloads for the iterative operations
`define FPM_ITER_MF      39
`define FPM_ITER_DF      40
`define FPM_ITER_MW      16
`define FPM_ITER_DW      17

// one-hot position of each decoded operation
`define FPM_OP_AD        0
`define FPM_OP_SD        1
`define FPM_OP_MW        2
`define FPM_OP_DW        3
`define FPM_OP_AF        4
`define FPM_OP_SF        5
`define FPM_OP_MF        6
`define FPM_OP_DF        7

`endif

/* logic/fpm_pkg.sv */
// types shared by the exponent section
// extended exponent word with signed and guard/exponent views

`include "fpm_settings.svh"

package fpm_pkg;

	// guard pair sits above the 8-bit exponent
	typedef struct packed {
		logic [`FPM_GUARD_W-1:0] guard;
		logic [`FPM_EXP_W-1:0]   exp;
	} exp_fields_t;

	// --------------------
	// one 10-bit word, two readings
	// signed for the adder and the alignment compare,
	// fields for the D register and overflow detection
	typedef union packed {
		logic signed [`FPM_XEXP_W-1:0] val;
		exp_fields_t                   f;
	} exp_word_u;

endpackage

/* logic/fpm_exp_path.sv */
// exponent datapath
// L bus select, D register with guard bits, B register,
// B bus modifier and the 10-bit exponent adder

`timescale 1ns/1ps
`include "fpm_settings.svh"

module fpm_exp_path
	import fpm_pkg::*;
(
	input  logic                  f2strob,
	input  logic                  arst_n,
	input  logic [`FPM_EXP_W-1:0] w,
	input  logic                  lkb,
	input  logic                  l_d,
	input  logic                  clr_d,
	input  logic                  f2,
	input  logic                  fcb,
	input  logic                  scc,
	input  logic                  pc8,
	output logic [`FPM_EXP_W-1:0] d,
	output exp_word_u             dx,
	output exp_word_u             sum
);

	logic [`FPM_XEXP_W-1:0] l_bus;
	logic [`FPM_EXP_W-1:0]  b;
	logic [`FPM_EXP_W-1:0]  b_bus;
	logic [`FPM_XEXP_W-1:0] b_ext;

	// --------------------
	// L bus

	always_comb begin
		if (lkb) begin
			// data word, sign copied into both guards
			l_bus = {{`FPM_GUARD_W{w[`FPM_EXP_W-1]}}, w};
		end else begin
			l_bus = sum;
		end
	end

	// --------------------
	// D and B registers

	// clear wins over load
	always_ff @(posedge f2strob or negedge arst_n) begin
		if (!arst_n) begin
			dx <= '0;
		end else if (clr_d) begin
			dx <= '0;
		end else if (l_d) begin
			dx <= l_bus;
		end
	end

	assign d = dx.f.exp;

	// B holds a copy of the exponent without guards
	always_ff @(posedge f2strob or negedge arst_n) begin
		if (!arst_n) begin
			b <= '0;
		end else if (f2) begin
			b <= dx.f.exp;
		end
	end

	// --------------------
	// B bus modifier and adder

	always_comb begin
		case ({fcb, scc})
			2'b00: b_bus = ~b;
			2'b01: b_bus = b;
			2'b10: b_bus = '1;
			default: b_bus = '0;
		endcase
	end

	assign b_ext = {{`FPM_GUARD_W{b_bus[`FPM_EXP_W-1]}}, b_bus};

	// wraps at 10 bits, guards carry the sign
	assign sum = b_ext + dx.val + {{(`FPM_XEXP_W-1){1'b0}}, pc8};

endmodule

/* logic/fpm_align_ctl.sv */
// alignment and exponent check control
// g, wdt and wt flags, counter load value and direction,
// exponent underflow and overflow indicators

`timescale 1ns/1ps
`include "fpm_settings.svh"

module fpm_align_ctl
	import fpm_pkg::*;
(
	input  logic                  f2strob,
	input  logic                  arst_n,
	input  logic                  f4,
	input  logic                  f5,
	input  logic                  f8,
	input  logic                  f13,
	input  logic                  clr_f,
	input  exp_word_u             sum,
	input  exp_word_u             dx,
	input  logic [`FPM_OPS_W-1:0] ops,
	input  logic                  af_sf,
	input  logic                  ff,
	output logic                  g,
	output logic                  wdt,
	output logic                  wt,
	output logic                  fic_load,
	output logic [`FPM_FIC_W-1:0] fic_value,
	output logic                  cnt_up,
	output logic                  cnt_down,
	output logic                  fi1,
	output logic                  fi2
);

	logic                   f5_af;
	logic                   neg;
	logic [`FPM_XEXP_W-1:0] mag;
	logic                   ge_limit;
	logic                   ovf_chk;
	logic                   exp_top;

	// --------------------
	// alignment flags

	assign f5_af    = f5 & af_sf;
	assign neg      = sum.val[`FPM_XEXP_W-1];
	// -512 wraps to itself, still read as 512 unsigned
	assign mag      = neg ? -sum.val : sum.val;
	assign ge_limit = (mag >= `FPM_ALIGN_LIMIT);

	always_ff @(posedge f2strob or negedge arst_n) begin
		if (!arst_n) begin
			g   <= 1'b0;
			wdt <= 1'b0;
			wt  <= 1'b0;
		end else if (clr_f) begin
			g   <= 1'b0;
			wdt <= 1'b0;
			wt  <= 1'b0;
		end else if (f5_af) begin
			g   <= ge_limit;
			wdt <= neg;
			wt  <= ge_limit & ~neg;
		end
	end

	// --------------------
	// counter load and direction

	assign fic_load = f4 | f5_af;

	// operation start takes precedence over alignment
	always_comb begin
		fic_value = '0;
		if (f4) begin
			case (1'b1)
				ops[`FPM_OP_MF]: fic_value = `FPM_FIC_W'(`FPM_ITER_MF);
				ops[`FPM_OP_DF]: fic_value = `FPM_FIC_W'(`FPM_ITER_DF);
				ops[`FPM_OP_MW]: fic_value = `FPM_FIC_W'(`FPM_ITER_MW);
				ops[`FPM_OP_DW]: fic_value = `FPM_FIC_W'(`FPM_ITER_DW);
				default: fic_value = '0;
			endcase
		end else if (f5_af) begin
			// exponent difference is the shift distance
			fic_value = sum.val[`FPM_FIC_W-1:0];
		end
	end

	// denormalized T counts up, otherwise down
	assign cnt_up   = f8 & wdt;
	assign cnt_down = f8 & ~wdt;

	// --------------------
	// exponent range check
	assign ovf_chk = ff & f13;
	assign exp_top = dx.f.exp[`FPM_EXP_W-1];

	assign fi2 = ovf_chk & (((dx.f.guard == 2'b00) & exp_top) | (dx.f.guard == 2'b01));
	assign fi1 = ovf_chk & ((dx.f.guard == 2'b10) | ((dx.f.guard == 2'b11) & ~exp_top));

endmodule

/* logic/fpm_fic.sv */
// shift and iteration counter
// loadable, counts up or down, saturates at both ends

`timescale 1ns/1ps
`include "fpm_settings.svh"

module fpm_fic (
	input  logic                  f2strob,
	input  logic                  arst_n,
	input  logic                  clr_f,
	input  logic                  fic_load,
	input  logic [`FPM_FIC_W-1:0] fic_value,
	input  logic                  cnt_up,
	input  logic                  cnt_down,
	output logic [`FPM_FIC_W-1:0] fic
);

	logic at_max;
	logic at_min;

	assign at_max = (fic == '1);
	assign at_min = (fic == '0);

	// clear, then load, then count
	always_ff @(posedge f2strob or negedge arst_n) begin
		if (!arst_n) begin
			fic <= '0;
		end else if (clr_f) begin
			fic <= '0;
		end else if (fic_load) begin
			fic <= fic_value;
		end else if (cnt_up) begin
			// hold at 63
			if (!at_max) begin
				fic <= fic + 1'b1;
			end
		end else if (cnt_down) begin
			// hold at zero
			if (!at_min) begin
				fic <= fic - 1'b1;
			end
		end
	end

endmodule

/* logic/fpm_op_decode.sv */
// arithmetic extension opcode decoder
// one-hot operation, group and class outputs

`timescale 1ns/1ps
`include "fpm_settings.svh"

module fpm_op_decode (
	input  logic [`FPM_OP_W-1:0]  op,
	input  logic                  pufa,
	input  logic                  nrf,
	output logic [`FPM_OPS_W-1:0] ops,
	output logic                  ad_sd,
	output logic                  af_sf,
	output logic                  mw_mf,
	output logic                  dw_df,
	output logic                  ff,
	output logic                  ss,
	output logic                  puf
);

	// enabled only by an extension instruction
	always_comb begin
		ops = '0;
		if (pufa) begin
			ops[op] = 1'b1;
		end
	end

	// --------------------
	// groups
	assign ad_sd = ops[`FPM_OP_AD] | ops[`FPM_OP_SD];
	assign af_sf = ops[`FPM_OP_AF] | ops[`FPM_OP_SF];
	assign mw_mf = ops[`FPM_OP_MW] | ops[`FPM_OP_MF];
	assign dw_df = ops[`FPM_OP_DW] | ops[`FPM_OP_DF];

	// floating point, fixed point, any extension op
	assign ff  = nrf | op[`FPM_OP_W-1];
	assign ss  = pufa & ~op[`FPM_OP_W-1];
	assign puf = pufa | nrf;

endmodule

/* logic/fpm.sv */
// exponent and sequencing section top level
// exponent path, opcode decoder, alignment control and counter

`timescale 1ns/1ps
`include "fpm_settings.svh"

module fpm
	import fpm_pkg::*;
(
	input  logic                  f2strob,
	input  logic                  arst_n,
	input  logic [`FPM_EXP_W-1:0] w,
	input  logic                  lkb,
	input  logic                  l_d,
	input  logic                  clr_d,
	input  logic                  f2,
	input  logic                  fcb,
	input  logic                  scc,
	input  logic                  pc8,
	input  logic                  f4,
	input  logic                  f5,
	input  logic                  f8,
	input  logic                  f13,
	input  logic                  clr_f,
	input  logic [`FPM_OP_W-1:0]  op,
	input  logic                  pufa,
	input  logic                  nrf,
	output logic [`FPM_EXP_W-1:0] d,
	output logic                  g,
	output logic                  wdt,
	output logic                  wt,
	output logic [`FPM_FIC_W-1:0] fic,
	output logic [`FPM_OPS_W-1:0] ops,
	output logic                  ad_sd,
	output logic                  af_sf,
	output logic                  mw_mf,
	output logic                  dw_df,
	output logic                  ff,
	output logic                  ss,
	output logic                  puf,
	output logic                  fi1,
	output logic                  fi2
);

	exp_word_u             sum;
	exp_word_u             dx;
	logic                  fic_load;
	logic [`FPM_FIC_W-1:0] fic_value;
	logic                  cnt_up;
	logic                  cnt_down;

	fpm_exp_path u_exp_path (
		.f2strob (f2strob),
		.arst_n  (arst_n),
		.w       (w),
		.lkb     (lkb),
		.l_d     (l_d),
		.clr_d   (clr_d),
		.f2      (f2),
		.fcb     (fcb),
		.scc     (scc),
		.pc8     (pc8),
		.d       (d),
		.dx      (dx),
		.sum     (sum)
	);

	fpm_op_decode u_op_decode (
		.op    (op),
		.pufa  (pufa),
		.nrf   (nrf),
		.ops   (ops),
		.ad_sd (ad_sd),
		.af_sf (af_sf),
		.mw_mf (mw_mf),
		.dw_df (dw_df),
		.ff    (ff),
		.ss    (ss),
		.puf   (puf)
	);

	// flags and counter control from the adder result
	fpm_align_ctl u_align_ctl (
		.f2strob   (f2strob),
		.arst_n    (arst_n),
		.f4        (f4),
		.f5        (f5),
		.f8        (f8),
		.f13       (f13),
		.clr_f     (clr_f),
		.sum       (sum),
		.dx        (dx),
		.ops       (ops),
		.af_sf     (af_sf),
		.ff        (ff),
		.g         (g),
		.wdt       (wdt),
		.wt        (wt),
		.fic_load  (fic_load),
		.fic_value (fic_value),
		.cnt_up    (cnt_up),
		.cnt_down  (cnt_down),
		.fi1       (fi1),
		.fi2       (fi2)
	);

	fpm_fic u_fic (
		.f2strob   (f2strob),
		.arst_n    (arst_n),
		.clr_f     (clr_f),
		.fic_load  (fic_load),
		.fic_value (fic_value),
		.cnt_up    (cnt_up),
		.cnt_down  (cnt_down),
		.fic       (fic)
	);

endmodule

/* bench/fpm_clkgen.sv */
// clock and reset source for the testbench
// 8 ns f2strob, arst_n held low for three rising edges

`timescale 1ns/1ps

module fpm_clkgen (
	output logic f2strob,
	output logic arst_n
);

	initial begin
		f2strob = 1'b0;
		forever #4 f2strob = ~f2strob;
	end

	// release away from the active edge
	initial begin
		arst_n = 1'b0;
		repeat (3) @(posedge f2strob);
		@(negedge f2strob);
		arst_n = 1'b1;
	end

endmodule

/* bench/fpm_asserts.sv */
// checker bound into the exponent section top level
// reference model of D, B, sum, flags and counter,
// concurrent assertions on every output group

`timescale 1ns/1ps
`include "fpm_settings.svh"

module fpm_asserts
	import fpm_pkg::*;
(
	input logic                  f2strob, arst_n,
	input logic [`FPM_EXP_W-1:0] w, d,
	input logic                  lkb, l_d, clr_d, f2, fcb, scc, pc8,
	input logic                  f4, f5, f8, f13, clr_f, pufa, nrf,
	input logic [`FPM_OP_W-1:0]  op,
	input logic [`FPM_FIC_W-1:0] fic,
	input logic [`FPM_OPS_W-1:0] ops,
	input logic                  g, wdt, wt, ad_sd, af_sf, mw_mf, dw_df,
	input logic                  ff, ss, puf, fi1, fi2
);

	exp_word_u             ref_d;
	exp_word_u             ref_sum;
	logic [`FPM_EXP_W-1:0] ref_b;
	logic [`FPM_EXP_W-1:0] ref_bbus;
	logic [2:0]            ref_flags;
	logic [`FPM_FIC_W-1:0] ref_fic;
	logic [`FPM_OPS_W-1:0] ref_ops;
	logic [3:0]            ref_grp;
	logic [2:0]            ref_cls;
	logic [1:0]            ref_fi;
	logic                  ref_align;
	int                    raw;
	int                    sv;
	int                    mag;
	int                    fail_count = 0;

	function automatic logic [`FPM_FIC_W-1:0] iter_count(input logic [`FPM_OP_W-1:0] opc);
		case (opc)
			`FPM_OP_MF: return `FPM_FIC_W'(`FPM_ITER_MF);
			`FPM_OP_DF: return `FPM_FIC_W'(`FPM_ITER_DF);
			`FPM_OP_MW: return `FPM_FIC_W'(`FPM_ITER_MW);
			`FPM_OP_DW: return `FPM_FIC_W'(`FPM_ITER_DW);
			default: return '0;
		endcase
	endfunction

	task automatic report_mismatch(input string name, input int exp_v, input int got_v);
		$error("mismatch t=%0t %s exp %0h got %0h", $time, name, exp_v, got_v);
		fail_count++;
	endtask

	// --------------------
	// expected combinational values
	always_comb begin
		case ({fcb, scc})
			2'b00: ref_bbus = ~ref_b;
			2'b01: ref_bbus = ref_b;
			2'b10: ref_bbus = 8'hff;
			default: ref_bbus = 8'h00;
		endcase
		// integer add, then wrap to the 10-bit word
		raw = int'($signed(ref_bbus)) + int'(ref_d.val) + int'(pc8);
		ref_sum.val = raw[`FPM_XEXP_W-1:0];
		sv = int'(ref_sum.val);
		mag = (sv < 0) ? -sv : sv;
		ref_ops = pufa ? (8'(1) << op) : '0;
		ref_align = f5 & (ref_ops[`FPM_OP_AF] | ref_ops[`FPM_OP_SF]);
		ref_grp[3] = ref_ops[`FPM_OP_AD] | ref_ops[`FPM_OP_SD];
		ref_grp[2] = ref_ops[`FPM_OP_AF] | ref_ops[`FPM_OP_SF];
		ref_grp[1] = ref_ops[`FPM_OP_MW] | ref_ops[`FPM_OP_MF];
		ref_grp[0] = ref_ops[`FPM_OP_DW] | ref_ops[`FPM_OP_DF];
		// floating ops occupy the upper half of the opcodes
		ref_cls[2] = nrf | (op >= 3'(`FPM_OP_AF));
		ref_cls[1] = |ref_ops[`FPM_OP_DW:`FPM_OP_AD];
		ref_cls[0] = pufa | nrf;
		// out of range below -128 or above 127
		ref_fi[1] = f13 & ref_cls[2] & (int'(ref_d.val) < -128);
		ref_fi[0] = f13 & ref_cls[2] & (int'(ref_d.val) > 127);
	end

	// --------------------
	// expected registers
	always_ff @(posedge f2strob or negedge arst_n) begin
		if (!arst_n) begin
			ref_d     <= '0;
			ref_b     <= '0;
			ref_flags <= '0;
			ref_fic   <= '0;
		end else begin
			if (clr_d)
				ref_d <= '0;
			else if (l_d)
				ref_d.val <= lkb ? 10'($signed(w)) : ref_sum.val;
			if (f2)
				ref_b <= ref_d.f.exp;
			// g, wdt, wt
			if (clr_f)
				ref_flags <= '0;
			else if (ref_align)
				ref_flags <= {mag >= `FPM_ALIGN_LIMIT, sv < 0,
					(mag >= `FPM_ALIGN_LIMIT) && (sv >= 0)};
			if (clr_f)
				ref_fic <= '0;
			else if (f4)
				ref_fic <= pufa ? iter_count(op) : '0;
			else if (ref_align)
				ref_fic <= ref_sum.val[`FPM_FIC_W-1:0];
			else if (f8 && ref_flags[1] && ref_fic != 6'd63)
				ref_fic <= ref_fic + 6'd1;
			else if (f8 && !ref_flags[1] && ref_fic != 6'd0)
				ref_fic <= ref_fic - 6'd1;
		end
	end

	// --------------------
	// output checks
	a_d: assert property (@(posedge f2strob) disable iff (!arst_n) d == ref_d.f.exp)
		else report_mismatch("d", ref_d.f.exp, d);
	a_flags: assert property (@(posedge f2strob) disable iff (!arst_n)
		{g, wdt, wt} == ref_flags)
		else report_mismatch("g/wdt/wt", ref_flags, {g, wdt, wt});
	a_fic: assert property (@(posedge f2strob) disable iff (!arst_n) fic == ref_fic)
		else report_mismatch("fic", ref_fic, fic);
	a_ops: assert property (@(posedge f2strob) disable iff (!arst_n) ops == ref_ops)
		else report_mismatch("ops", ref_ops, ops);
	a_grp: assert property (@(posedge f2strob) disable iff (!arst_n)
		{ad_sd, af_sf, mw_mf, dw_df} == ref_grp)
		else report_mismatch("ad_sd/af_sf/mw_mf/dw_df", ref_grp,
			{ad_sd, af_sf, mw_mf, dw_df});
	a_class: assert property (@(posedge f2strob) disable iff (!arst_n)
		{ff, ss, puf} == ref_cls)
		else report_mismatch("ff/ss/puf", ref_cls, {ff, ss, puf});
	a_fi: assert property (@(posedge f2strob) disable iff (!arst_n) {fi1, fi2} == ref_fi)
		else report_mismatch("fi1/fi2", ref_fi, {fi1, fi2});

	// state must come out of reset idle
	a_rst: assert property (@(posedge f2strob)
		$rose(arst_n) |-> (d == '0) && !g && !wdt && !wt && (fic == '0))
		else begin
			$error("registers were not cleared by reset");
			fail_count++;
		end

endmodule

/* bench/fpm_tb.sv */
// testbench top for the exponent section
// clock source, DUT, bound checker, directed and random stimulus,
// failure monitor and watchdog

`timescale 1ns/1ps

module fpm_tb;

	localparam int DIRECTED_CYCLES = 300;
	localparam int RANDOM_CYCLES   = 300;
	localparam int RUN_NS          = 2 * (3 + DIRECTED_CYCLES + RANDOM_CYCLES) * 8;

	logic       f2strob;
	logic       arst_n;
	logic [7:0] w;
	logic [7:0] d;
	logic [7:0] ops;
	logic [7:0] a;
	logic [7:0] b;
	logic [5:0] fic;
	logic [2:0] op;
	logic       lkb, l_d, clr_d, f2, fcb, scc, pc8;
	logic       f4, f5, f8, f13, clr_f, pufa, nrf;
	logic       g, wdt, wt, ad_sd, af_sf, mw_mf, dw_df, ff, ss, puf, fi1, fi2;
	// exponent differences around the saturation points and the limit
	int         diffs[8] = '{-1, -2, 3, 62, 40, -40, 39, -39};
	logic [7:0] fi_starts[4] = '{8'd127, 8'd100, 8'h80, 8'h9c};

	fpm_clkgen u_clkgen (
		.f2strob (f2strob),
		.arst_n  (arst_n)
	);

	fpm DUT (.*);

	bind fpm fpm_asserts u_asserts (.*);

	// advance to the next falling edge, strobes back low
	task automatic tick();
		@(negedge f2strob);
		{l_d, clr_d, f2, f4, f5, f8, clr_f} = '0;
	endtask

	task automatic load_word(input logic [7:0] val);
		w = val;
		lkb = 1'b1;
		l_d = 1'b1;
		tick();
	endtask

	task automatic load_sum(input logic [1:0] mode, input logic carry);
		lkb = 1'b0;
		{fcb, scc} = mode;
		pc8 = carry;
		l_d = 1'b1;
		tick();
	endtask

	initial begin
		{w, op, lkb, l_d, clr_d, f2, fcb, scc, pc8, f4, f5, f8, f13, clr_f, pufa, nrf} = '0;
		void'($urandom(93832));
		wait (arst_n === 1'b1);
		tick();
		// --------------------
		// D load and clear
		for (int i = 0; i < 8; i++) begin
			load_word(8'($urandom));
			clr_d = 1'b1;
			tick();
		end
		// adder in each B bus mode
		for (int m = 0; m < 8; m++) begin
			load_word(8'($urandom));
			f2 = 1'b1;
			tick();
			load_word(8'($urandom));
			load_sum(2'(m >> 1), m[0]);
		end
		// --------------------
		// alignment, counter direction and saturation
		pufa = 1'b1;
		for (int k = 0; k < 12; k++) begin
			op = k[0] ? 3'd5 : 3'd4;
			a = (k < 8) ? 8'd20 : 8'($urandom);
			b = (k < 8) ? 8'(20 + diffs[k]) : 8'($urandom);
			load_word(a);
			f2 = 1'b1;
			tick();
			load_word(b);
			{fcb, scc, pc8, f5} = 4'b0011;
			tick();
			repeat (6) begin
				f8 = 1'b1;
				tick();
			end
			clr_f = 1'b1;
			tick();
		end
		// fixed iteration loads
		for (int o = 0; o < 8; o++) begin
			op = 3'(o);
			f4 = 1'b1;
			tick();
			repeat (3) begin
				f8 = 1'b1;
				tick();
			end
			clr_f = 1'b1;
			tick();
		end
		// decoder over every opcode and class input
		for (int n = 0; n < 32; n++) begin
			{nrf, pufa, op} = 5'(n);
			tick();
		end
		// --------------------
		// exponent range check, D stepped by B through the adder
		{nrf, pufa, f13} = 3'b101;
		for (int s = 0; s < 4; s++) begin
			load_word(fi_starts[s]);
			f2 = 1'b1;
			tick();
			repeat (5) load_sum(2'b01, 1'b0);
		end
		{nrf, f13} = 2'b00;
		repeat (RANDOM_CYCLES) begin
			{w, op, lkb, l_d, clr_d, f2, fcb, scc, pc8, f4, f5, f8, f13, clr_f, pufa, nrf} =
				25'($urandom);
			@(negedge f2strob);
		end
		f13 = 1'b0;
		repeat (2) tick();
		if (DUT.u_asserts.fail_count == 0) begin
			$display("TB PASSED");
			$finish;
		end else begin
			$display("TB FAILED");
			$fatal(1, "checker reported failures");
		end
	end

	// stop at the first failing assertion
	initial begin
		wait (DUT.u_asserts.fail_count > 0);
		$display("TB FAILED");
		$fatal(1, "first failing check reached, run stopped");
	end

	initial begin
		#(RUN_NS);
		$display("TB FAILED");
		$fatal(1, "run hung, no end after %0d ns", RUN_NS);
	end

endmodule

/* vlog.f */
+incdir+logic
logic/fpm_pkg.sv
logic/fpm_exp_path.sv
logic/fpm_align_ctl.sv
logic/fpm_fic.sv
logic/fpm_op_decode.sv
logic/fpm.sv
bench/fpm_clkgen.sv
bench/fpm_asserts.sv
bench/fpm_tb.sv

/* run.sh */
#!/bin/sh
# build and run the fpm testbench with Verilator, verdict taken from the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module fpm_tb -f vlog.f -o fpm_sim \
	|| { echo "build failed"; exit 1; }
./obj_dir/fpm_sim +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log
grep -q "TB FAILED" sim.log && { echo "simulation failed"; exit 1; }
grep -q "TB PASSED" sim.log || { echo "simulation ended without a verdict"; exit 1; }
exit 0
